// File: filelist.f
logic/video_pkg.sv
logic/vram_pkg.sv
logic/vram.sv
logic/vram_arbiter.sv
logic/row_renderer.sv
logic/row_buffer.sv
logic/video_timing.sv
logic/fpgame_video.sv
verification/fpgame_video_properties.sv
verification/fpgame_video_tb.sv

// File: logic/fpgame_video.sv
`timescale 1ns/1ns

module fpgame_video (
    input  logic                 clk,
    input  logic                 reset,

    // Host write port
    input  vram_pkg::vram_addr_t h2f_vram_wraddr,
    input  vram_pkg::vram_data_t h2f_vram_wrdata,
    input  vram_pkg::vram_be_t   h2f_vram_byteena,
    input  logic                 h2f_vram_wren,
    output logic                 cpu_wr_busy,

    // Video out
    output logic                 vid_de,
    output logic                 vid_hs,
    output logic                 vid_vs,
    output video_pkg::rgb_t      vid_rgb
);

    import video_pkg::*;
    import vram_pkg::*;

    // ==========================================================================
    // Interconnect
    // ==========================================================================
    // Renderer to arbiter
    logic       rd_req;
    vram_addr_t rd_addr;
    logic       rd_valid;
    vram_data_t rd_data;

    // Arbiter to RAM
    logic       mem_we;
    logic       mem_re;
    vram_addr_t mem_addr;
    vram_data_t mem_wdata;
    vram_be_t   mem_be;
    vram_data_t mem_rdata;

    // Renderer, row buffer and timing
    logic       next_row;
    row_t       next_row_num;
    logic       rowram_swap;
    logic       fill_we;
    col_t       fill_addr;
    pix_index_t fill_data;
    col_t       scan_addr;
    pix_index_t scan_data;

    // ==========================================================================
    // Submodules
    // ==========================================================================
    vram_arbiter u_arbiter (
        .clk,
        .reset,
        .h2f_vram_wraddr,
        .h2f_vram_wrdata,
        .h2f_vram_byteena,
        .h2f_vram_wren,
        .cpu_wr_busy,
        .rd_req,
        .rd_addr,
        .rd_valid,
        .rd_data,
        .mem_we,
        .mem_re,
        .mem_addr,
        .mem_wdata,
        .mem_be,
        .mem_rdata
    );

    vram u_vram (
        .clk,
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .be    (mem_be),
        .re    (mem_re),
        .rdata (mem_rdata)
    );

    row_renderer u_renderer (
        .clk,
        .reset,
        .next_row,
        .next_row_num,
        .rd_req,
        .rd_addr,
        .rd_valid,
        .rd_data,
        .fill_we,
        .fill_addr,
        .fill_data
    );

    row_buffer u_rowbuf (
        .clk,
        .reset,
        .rowram_swap,
        .fill_we,
        .fill_addr,
        .fill_data,
        .scan_addr,
        .scan_data
    );

    video_timing u_timing (
        .clk,
        .reset,
        .next_row,
        .next_row_num,
        .rowram_swap,
        .scan_addr,
        .scan_data,
        .vid_de,
        .vid_hs,
        .vid_vs,
        .vid_rgb
    );

endmodule : fpgame_video

// File: logic/row_buffer.sv
`timescale 1ns/1ns

module row_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rowram_swap,

    // Fill side from the renderer
    input  logic                  fill_we,
    input  video_pkg::col_t       fill_addr,
    input  video_pkg::pix_index_t fill_data,

    // Scan side to the timing generator
    input  video_pkg::col_t       scan_addr,
    output video_pkg::pix_index_t scan_data
);

    import video_pkg::*;

    pix_index_t bank [2][H_ACTIVE];
    // Selects the fill bank; scan reads the other one
    logic       sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            sel <= 1'b0;
        end else if (rowram_swap) begin
            sel <= ~sel;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            bank[sel][fill_addr] <= fill_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        scan_data <= bank[~sel][scan_addr];
    end

endmodule : row_buffer

// File: logic/row_renderer.sv
`timescale 1ns/1ns

module row_renderer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  next_row,
    input  video_pkg::row_t       next_row_num,

    // Word reads through the arbiter
    output logic                  rd_req,
    output vram_pkg::vram_addr_t  rd_addr,
    input  logic                  rd_valid,
    input  vram_pkg::vram_data_t  rd_data,

    // Row buffer fill
    output logic                  fill_we,
    output video_pkg::col_t       fill_addr,
    output video_pkg::pix_index_t fill_data
);

    import video_pkg::*;
    import vram_pkg::*;

    logic                             fetching;
    row_t                             row_q;
    logic [$clog2(WORDS_PER_ROW)-1:0] word_cnt;
    // Words issued and not yet fully unpacked, at most two
    logic [1:0]                       inflight;

    vram_data_t                       shift_reg;
    logic                             shift_valid;
    logic [$clog2(PIX_PER_WORD)-1:0]  pix_cnt;
    vram_data_t                       pend_word;
    logic                             pend_valid;
    col_t                             col;

    logic                             last_pix;
    logic                             word_done;
    logic                             load_new;

    assign last_pix  = (pix_cnt == 3'(PIX_PER_WORD - 1));
    assign word_done = shift_valid && last_pix;
    assign load_new  = rd_valid && (!shift_valid || last_pix);

    // ==========================================================================
    // Fetch side
    // ==========================================================================
    assign rd_req  = fetching && (inflight != 2'd2);
    assign rd_addr = {row_q, word_cnt};

    always_ff @(posedge clk) begin
        if (reset) begin
            fetching <= 1'b0;
            word_cnt <= '0;
            inflight <= '0;
        end else begin
            if (next_row) begin
                fetching <= 1'b1;
                row_q    <= next_row_num;
                word_cnt <= '0;
            end else if (rd_req) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == 3'(WORDS_PER_ROW - 1)) fetching <= 1'b0;
            end
            inflight <= inflight + 2'(rd_req) - 2'(word_done);
        end
    end

    // ==========================================================================
    // Unpack side
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_valid <= 1'b0;
            pend_valid  <= 1'b0;
            pix_cnt     <= '0;
            col         <= '0;
        end else begin
            if (load_new || (word_done && pend_valid)) shift_valid <= 1'b1;
            else if (word_done) shift_valid <= 1'b0;

            // Word arriving mid-unpack waits here
            if (rd_valid && !load_new) pend_valid <= 1'b1;
            else if (word_done) pend_valid <= 1'b0;

            if (shift_valid) pix_cnt <= pix_cnt + 1'b1;

            if (next_row) col <= '0;
            else if (shift_valid) col <= col + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_new) shift_reg <= rd_data;
        else if (word_done && pend_valid) shift_reg <= pend_word;
        else if (shift_valid) shift_reg <= shift_reg >> $bits(pix_index_t);

        if (rd_valid && !load_new) pend_word <= rd_data;
    end

    assign fill_we   = shift_valid;
    assign fill_addr = col;
    assign fill_data = shift_reg[$bits(pix_index_t)-1:0];

endmodule : row_renderer

// File: logic/video_pkg.sv
package video_pkg;

    // ==========================================================================
    // Raster timing, in clocks per line and lines per frame
    // ==========================================================================
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 32;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Counters and coordinates
    typedef logic [6:0] hcount_t;
    typedef logic [5:0] vcount_t;
    typedef logic [4:0] row_t;
    typedef logic [5:0] col_t;

    // ==========================================================================
    // Pixel formats
    // ==========================================================================
    typedef logic [7:0]  pix_index_t;
    typedef logic [23:0] rgb_t;

    // 3-3-2 field positions inside a pixel index
    localparam int RED_HI = 7;
    localparam int RED_LO = 5;
    localparam int GRN_HI = 4;
    localparam int GRN_LO = 2;
    localparam int BLU_HI = 1;
    localparam int BLU_LO = 0;

endpackage : video_pkg

// File: logic/video_timing.sv
`timescale 1ns/1ns

module video_timing (
    input  logic                  clk,
    input  logic                  reset,

    // Row requests to the renderer
    output logic                  next_row,
    output video_pkg::row_t       next_row_num,

    // Row buffer control and scan-out
    output logic                  rowram_swap,
    output video_pkg::col_t       scan_addr,
    input  video_pkg::pix_index_t scan_data,

    // DVI-style pixel output
    output logic                  vid_de,
    output logic                  vid_hs,
    output logic                  vid_vs,
    output video_pkg::rgb_t       vid_rgb
);

    import video_pkg::*;

    hcount_t h_count;
    vcount_t v_count;
    logic    line_end;
    logic    frame_end;
    logic    active;
    logic    hs_now;
    logic    vs_now;
    logic    feeds_active;

    // First pipeline stage, lined up with the buffer read
    logic    de_d1;
    logic    hs_d1;
    logic    vs_d1;

    // Widen each colour field by repeating its bits
    function automatic rgb_t expand(input pix_index_t idx);
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
        r = idx[RED_HI:RED_LO];
        g = idx[GRN_HI:GRN_LO];
        b = idx[BLU_HI:BLU_LO];
        return {r, r, r[2:1], g, g, g[2:1], b, b, b, b};
    endfunction

    // ==========================================================================
    // Raster counters
    // ==========================================================================
    assign line_end  = (h_count == hcount_t'(H_TOTAL - 1));
    assign frame_end = (v_count == vcount_t'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= frame_end ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign active = (h_count < hcount_t'(H_ACTIVE)) && (v_count < vcount_t'(V_ACTIVE));
    assign hs_now = (h_count >= hcount_t'(H_ACTIVE + H_FRONT))
                 && (h_count <  hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign vs_now = (v_count >= vcount_t'(V_ACTIVE + V_FRONT))
                 && (v_count <  vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));

    // Lines whose next line shows pixels, the last frame line included
    assign feeds_active = (v_count < vcount_t'(V_ACTIVE - 1)) || frame_end;

    // ==========================================================================
    // Row requests and buffer swaps
    // ==========================================================================
    // Request lands just after the previous swap so a fill never straddles one
    always_ff @(posedge clk) begin
        if (reset) begin
            next_row     <= 1'b0;
            next_row_num <= '0;
            rowram_swap  <= 1'b0;
        end else begin
            next_row     <= (h_count == '0) && feeds_active;
            next_row_num <= frame_end ? '0 : row_t'(v_count + 1'b1);
            // Pulse falls on the last count of the line
            rowram_swap  <= (h_count == hcount_t'(H_TOTAL - 2)) && feeds_active;
        end
    end

    assign scan_addr = col_t'(h_count);

    // ==========================================================================
    // Output pipeline
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            de_d1   <= 1'b0;
            hs_d1   <= 1'b0;
            vs_d1   <= 1'b0;
            vid_de  <= 1'b0;
            vid_hs  <= 1'b0;
            vid_vs  <= 1'b0;
            vid_rgb <= '0;
        end else begin
            de_d1   <= active;
            hs_d1   <= hs_now;
            vs_d1   <= vs_now;
            vid_de  <= de_d1;
            vid_hs  <= hs_d1;
            vid_vs  <= vs_d1;
            // Black outside the active area
            vid_rgb <= de_d1 ? expand(scan_data) : '0;
        end
    end

endmodule : video_timing

// File: logic/vram.sv
`timescale 1ns/1ns

module vram (
    input  logic                 clk,
    input  logic                 we,
    input  vram_pkg::vram_addr_t addr,
    input  vram_pkg::vram_data_t wdata,
    input  vram_pkg::vram_be_t   be,
    input  logic                 re,
    output vram_pkg::vram_data_t rdata
);

    import vram_pkg::*;

    vram_data_t mem [VRAM_WORDS];

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < PIX_PER_WORD; i++) begin
                if (be[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read data is valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule : vram

// File: logic/vram_arbiter.sv
`timescale 1ns/1ns

module vram_arbiter (
    input  logic                 clk,
    input  logic                 reset,

    // Host write port
    input  vram_pkg::vram_addr_t h2f_vram_wraddr,
    input  vram_pkg::vram_data_t h2f_vram_wrdata,
    input  vram_pkg::vram_be_t   h2f_vram_byteena,
    input  logic                 h2f_vram_wren,
    output logic                 cpu_wr_busy,

    // Renderer reads
    input  logic                 rd_req,
    input  vram_pkg::vram_addr_t rd_addr,
    output logic                 rd_valid,
    output vram_pkg::vram_data_t rd_data,

    // RAM side
    output logic                 mem_we,
    output logic                 mem_re,
    output vram_pkg::vram_addr_t mem_addr,
    output vram_pkg::vram_data_t mem_wdata,
    output vram_pkg::vram_be_t   mem_be,
    input  vram_pkg::vram_data_t mem_rdata
);

    import vram_pkg::*;

    arb_state_t state;
    vram_addr_t slot_addr;
    vram_data_t slot_data;
    vram_be_t   slot_be;
    logic       holding;

    assign holding = (state == ARB_HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ARB_IDLE;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_req;
            case (state)
                ARB_IDLE: if (h2f_vram_wren && rd_req) state <= ARB_HOLD;
                ARB_HOLD: if (!rd_req) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

    // Write slot, only loaded while empty
    always_ff @(posedge clk) begin
        if (h2f_vram_wren && !holding) begin
            slot_addr <= h2f_vram_wraddr;
            slot_data <= h2f_vram_wrdata;
            slot_be   <= h2f_vram_byteena;
        end
    end

    // Reads win; a write goes straight through when the port is free
    always_comb begin
        mem_re    = rd_req;
        mem_we    = !rd_req && (holding || h2f_vram_wren);
        mem_addr  = holding ? slot_addr : h2f_vram_wraddr;
        mem_wdata = holding ? slot_data : h2f_vram_wrdata;
        mem_be    = holding ? slot_be   : h2f_vram_byteena;
        if (rd_req) begin
            mem_addr = rd_addr;
        end
    end

    assign rd_data     = mem_rdata;
    assign cpu_wr_busy = holding;

endmodule : vram_arbiter

// File: logic/vram_pkg.sv
package vram_pkg;

    // ==========================================================================
    // Video RAM geometry
    // ==========================================================================
    localparam int VRAM_WORDS    = 256;
    // Lowest byte of a word is the leftmost pixel
    localparam int PIX_PER_WORD  = 8;
    localparam int WORDS_PER_ROW = 8;

    // Word for row r, column c sits at r*8 + c
    typedef logic [$clog2(VRAM_WORDS)-1:0] vram_addr_t;
    typedef logic [PIX_PER_WORD*8-1:0]     vram_data_t;
    // One enable per byte
    typedef logic [PIX_PER_WORD-1:0]       vram_be_t;

    // ==========================================================================
    // Arbiter
    // ==========================================================================
    // HOLD means a host write sits in the slot
    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_t;

endpackage : vram_pkg

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module fpgame_video_tb -o fpgame_video_sim

# A stopped simulation still leaves its log for the checks below
./obj_dir/fpgame_video_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi

// File: verification/fpgame_video_properties.sv
`timescale 1ns/1ns

module fpgame_video_properties (
    input logic clk,
    input logic reset,
    input logic h2f_vram_wren,
    input logic cpu_wr_busy,
    input logic vid_de,
    input logic vid_hs,
    input logic vid_vs
);

    import video_pkg::*;

    localparam int VS_CYCLES = V_SYNC * H_TOTAL;
    // A held write waits out at most one 8-read row fetch
    localparam int BUSY_MAX  = 9;

    int busy_len;
    int vs_len;

    // Consecutive high samples so far
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_len <= 0;
            vs_len   <= 0;
        end else begin
            busy_len <= cpu_wr_busy ? busy_len + 1 : 0;
            vs_len   <= vid_vs ? vs_len + 1 : 0;
        end
    end

    outputs_low_after_reset: assert property (@(posedge clk)
        reset |=> !cpu_wr_busy && !vid_de && !vid_hs && !vid_vs)
        else $error("outputs not low after reset");

    no_write_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(h2f_vram_wren && cpu_wr_busy))
        else $error("host write issued while cpu_wr_busy is high");

    busy_is_short: assert property (@(posedge clk) disable iff (reset)
        cpu_wr_busy |-> busy_len < BUSY_MAX)
        else $error("cpu_wr_busy stayed high too long");

    de_outside_sync: assert property (@(posedge clk) disable iff (reset)
        !(vid_de && (vid_hs || vid_vs)))
        else $error("vid_de overlaps a sync pulse");

    vsync_width: assert property (@(posedge clk) disable iff (reset)
        $fell(vid_vs) |-> vs_len == VS_CYCLES)
        else $error("vid_vs pulse width wrong");

endmodule : fpgame_video_properties

// File: verification/fpgame_video_tb.sv
`timescale 1ns/1ns

module fpgame_video_tb;

    import video_pkg::*;
    import vram_pkg::*;

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // About six frames of tests, with generous margin
    localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES;
    localparam int CHECKED_FRAMES = 3;

    logic       clk;
    logic       reset;
    vram_addr_t h2f_vram_wraddr;
    vram_data_t h2f_vram_wrdata;
    vram_be_t   h2f_vram_byteena;
    logic       h2f_vram_wren;
    logic       cpu_wr_busy;
    logic       vid_de;
    logic       vid_hs;
    logic       vid_vs;
    rgb_t       vid_rgb;

    // Reference copy of the video RAM
    vram_data_t model [VRAM_WORDS];

    int   seed;
    int   cycle_count = 0;
    int   busy_hits   = 0;
    int   checked_px  = 0;
    logic check_on    = 1'b0;

    // Frame monitor state
    int   pix_cnt;
    int   line_cnt;
    int   hs_len;
    int   hs_gap;
    int   vs_gap;
    logic de_prev;
    logic hs_prev;
    logic vs_prev;
    logic hs_seen;
    logic vs_seen;
    rgb_t expected;

    fpgame_video dut (
        .clk,
        .reset,
        .h2f_vram_wraddr,
        .h2f_vram_wrdata,
        .h2f_vram_byteena,
        .h2f_vram_wren,
        .cpu_wr_busy,
        .vid_de,
        .vid_hs,
        .vid_vs,
        .vid_rgb
    );

    bind fpgame_video fpgame_video_properties props (
        .clk           (clk),
        .reset         (reset),
        .h2f_vram_wren (h2f_vram_wren),
        .cpu_wr_busy   (cpu_wr_busy),
        .vid_de        (vid_de),
        .vid_hs        (vid_hs),
        .vid_vs        (vid_vs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // 3-3-2 index widened to 8 bits per channel by repeating each field
    function automatic rgb_t to_rgb(input pix_index_t idx);
        logic [8:0] red3;
        logic [8:0] grn3;
        red3 = {3{idx[7:5]}};
        grn3 = {3{idx[4:2]}};
        return {red3[8:1], grn3[8:1], {4{idx[1:0]}}};
    endfunction

    function automatic rgb_t model_pixel(input int row, input int x);
        vram_data_t word;
        pix_index_t idx;
        word = model[(row * WORDS_PER_ROW + x / PIX_PER_WORD) % VRAM_WORDS];
        idx  = word[(x % PIX_PER_WORD) * 8 +: 8];
        return to_rgb(idx);
    endfunction

    // One host write, then a gap cycle so busy is seen before the next one
    task automatic write_word(input vram_addr_t addr, input vram_data_t data,
                              input vram_be_t be);
        while (cpu_wr_busy) @(posedge clk);
        h2f_vram_wraddr  <= addr;
        h2f_vram_wrdata  <= data;
        h2f_vram_byteena <= be;
        h2f_vram_wren    <= 1'b1;
        for (int i = 0; i < PIX_PER_WORD; i++) begin
            if (be[i]) model[addr][i*8 +: 8] = data[i*8 +: 8];
        end
        @(posedge clk);
        h2f_vram_wren <= 1'b0;
        @(posedge clk);
        if (cpu_wr_busy) busy_hits++;
    endtask

    task automatic wait_vsync_rise();
        @(posedge clk);
        while (vid_vs) @(posedge clk);
        while (!vid_vs) @(posedge clk);
    endtask

    task automatic wait_line_start();
        @(posedge clk);
        while (vid_de) @(posedge clk);
        while (!vid_de) @(posedge clk);
    endtask

    // Frame after the next vertical sync is built from settled RAM contents
    task automatic check_next_frame();
        while (cpu_wr_busy) @(posedge clk);
        wait_vsync_rise();
        check_on <= 1'b1;
        wait_vsync_rise();
        check_on <= 1'b0;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        seed             = 58;
        reset            = 1'b1;
        h2f_vram_wraddr  = '0;
        h2f_vram_wrdata  = '0;
        h2f_vram_byteena = '0;
        h2f_vram_wren    = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Full bitmap, all bytes enabled
        for (int a = 0; a < VRAM_WORDS; a++) begin
            write_word(vram_addr_t'(a), {$random(seed), $random(seed)}, '1);
        end
        check_next_frame();

        // Partial byte enables leave the other pixels alone
        for (int n = 0; n < 64; n++) begin
            write_word(vram_addr_t'($random(seed)), {$random(seed), $random(seed)},
                       vram_be_t'($random(seed)));
        end
        check_next_frame();

        // Burst starting at a line start overlaps the row fetch
        busy_hits = 0;
        wait_line_start();
        for (int n = 0; n < 64; n++) begin
            write_word(vram_addr_t'($random(seed)), {$random(seed), $random(seed)}, '1);
        end
        assert (busy_hits > 0) else begin
            $display("cpu_wr_busy never went high during the line-start write burst");
            abort_run();
        end
        check_next_frame();

        assert (checked_px == CHECKED_FRAMES * H_ACTIVE * V_ACTIVE) else begin
            $display("CHECK FAILED checked pixels: expected %h, got %h",
                     CHECKED_FRAMES * H_ACTIVE * V_ACTIVE, checked_px);
            abort_run();
        end
        $display("Test passed");
        $finish;
    end

    // ========================================================================
    // Frame monitor
    // ========================================================================
    always @(posedge clk) begin
        if (reset) begin
            pix_cnt  = 0;
            line_cnt = 0;
            hs_len   = 0;
            hs_gap   = 0;
            vs_gap   = 0;
            de_prev  = 1'b0;
            hs_prev  = 1'b0;
            vs_prev  = 1'b0;
            hs_seen  = 1'b0;
            vs_seen  = 1'b0;
        end else begin
            hs_gap = hs_gap + 1;
            vs_gap = vs_gap + 1;

            if (vid_de) begin
                if (check_on) begin
                    expected = model_pixel(line_cnt, pix_cnt);
                    assert (vid_rgb == expected) else begin
                        $display("CHECK FAILED vid_rgb: expected %h, got %h (line %0d, pixel %0d)",
                                 expected, vid_rgb, line_cnt, pix_cnt);
                        abort_run();
                    end
                    checked_px++;
                end
                pix_cnt++;
            end else if (de_prev) begin
                assert (pix_cnt == H_ACTIVE) else begin
                    $display("CHECK FAILED vid_de pixels per line: expected %h, got %h",
                             H_ACTIVE, pix_cnt);
                    abort_run();
                end
                line_cnt++;
                pix_cnt = 0;
            end

            // Horizontal sync width and period
            if (vid_hs) hs_len++;
            if (vid_hs && !hs_prev) begin
                if (hs_seen) begin
                    assert (hs_gap == H_TOTAL) else begin
                        $display("CHECK FAILED vid_hs period: expected %h, got %h",
                                 H_TOTAL, hs_gap);
                        abort_run();
                    end
                end
                hs_seen = 1'b1;
                hs_gap  = 0;
            end
            if (!vid_hs && hs_prev) begin
                assert (hs_len == H_SYNC) else begin
                    $display("CHECK FAILED vid_hs width: expected %h, got %h", H_SYNC, hs_len);
                    abort_run();
                end
                hs_len = 0;
            end

            if (vid_vs && !vs_prev) begin
                assert (line_cnt == V_ACTIVE) else begin
                    $display("CHECK FAILED vid_de lines per frame: expected %h, got %h",
                             V_ACTIVE, line_cnt);
                    abort_run();
                end
                if (vs_seen) begin
                    assert (vs_gap == FRAME_CYCLES) else begin
                        $display("CHECK FAILED vid_vs period: expected %h, got %h",
                                 FRAME_CYCLES, vs_gap);
                        abort_run();
                    end
                end
                vs_seen = 1'b1;
                vs_gap  = 0;
            end
            if (vid_vs) line_cnt = 0;

            de_prev = vid_de;
            hs_prev = vid_hs;
            vs_prev = vid_vs;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            abort_run();
        end
    end

endmodule : fpgame_video_tb
